//--- design/lpc_pkg.sv
package lpc_pkg;

	////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////

	// Signed speech sample
	typedef logic signed [15:0] sample_t;

	// Product after the arithmetic shift
	typedef logic signed [31:0] prod_t;

	// Lag accumulator with eight guard bits
	typedef logic signed [39:0] acc_t;

	// Saturated lag result
	typedef logic signed [31:0] corr_t;

	////////////////////////////////////////
	// Controller states
	////////////////////////////////////////

	typedef enum logic [2:0] {
		IDLE,
		LOAD_WAIT,
		MAC_RUN,
		MAC_STORE,
		EMIT
	} ctrl_state_t;

endpackage

//--- design/mac_ctrl_if.sv
`timescale 1ns/1ns

interface mac_ctrl_if #(
	parameter int FRAME_LEN = 80,
	parameter int LAG_COUNT = 10
);
	localparam int ADDR_W = $clog2(FRAME_LEN);
	localparam int IDX_W = $clog2(LAG_COUNT);

	// Read side of the frame buffer
	logic              rd_bank;
	logic [ADDR_W-1:0] rd_addr_a;
	logic [ADDR_W-1:0] rd_addr_b;

	// Accumulator control, already aligned to the MAC pipeline
	logic              mac_clear;
	logic              mac_en;
	logic              store_en;
	logic [IDX_W-1:0]  store_idx;

	// Kicks off the output stream
	logic              emit_start;

	modport ctrl (output rd_bank, rd_addr_a, rd_addr_b, mac_clear, mac_en,
		store_en, store_idx, emit_start);
	modport buf_side (input rd_bank, rd_addr_a, rd_addr_b);
	modport mac_side (input mac_clear, mac_en, store_en);
	modport ser_side (input store_en, store_idx, emit_start);

endinterface

//--- design/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer #(
	parameter int FRAME_LEN = 80,
	localparam int ADDR_W = $clog2(FRAME_LEN)
) (
	input  logic              clock,
	input  logic              start,
	input  lpc_pkg::sample_t  in,
	input  logic [ADDR_W-1:0] wr_addr,
	mac_ctrl_if.buf_side      bus,
	output lpc_pkg::sample_t  rd_data_a,
	output lpc_pkg::sample_t  rd_data_b
);

	// Two banks, one filling while the other is read
	lpc_pkg::sample_t mem [2][FRAME_LEN];

	logic wr_bank;

	// Always write the bank that is not being read
	assign wr_bank = ~bus.rd_bank;

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		// One sample per start strobe
		if (start)
		begin
			mem[wr_bank][wr_addr] <= in;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Port a gives x[n], port b gives x[n-k]
	// Data valid one cycle after the address
	always_ff @(posedge clock)
	begin
		rd_data_a <= mem[bus.rd_bank][bus.rd_addr_a];
		rd_data_b <= mem[bus.rd_bank][bus.rd_addr_b];
	end

endmodule

//--- design/lag_mac.sv
`timescale 1ns/1ns

module lag_mac #(
	parameter int PROD_SHIFT = 6
) (
	input  logic             clock,
	input  logic             rst_n,
	input  lpc_pkg::sample_t rd_data_a,
	input  lpc_pkg::sample_t rd_data_b,
	mac_ctrl_if.mac_side     bus,
	output lpc_pkg::corr_t   result
);

	// Saturation bounds, 32-bit range seen from the 40-bit accumulator
	localparam lpc_pkg::acc_t ACC_MAX = lpc_pkg::acc_t'(32'sh7FFF_FFFF);
	localparam lpc_pkg::acc_t ACC_MIN = -ACC_MAX - 1;

	lpc_pkg::prod_t prod_full;
	lpc_pkg::prod_t prod_q;
	lpc_pkg::acc_t  acc;
	lpc_pkg::acc_t  acc_base;
	lpc_pkg::acc_t  acc_add;

	// Clamp to signed 32 bits
	function automatic lpc_pkg::corr_t saturate(input lpc_pkg::acc_t value);
		lpc_pkg::corr_t clamped;
		if (value > ACC_MAX)
		begin
			clamped = 32'sh7FFF_FFFF;
		end
		else if (value < ACC_MIN)
		begin
			clamped = 32'sh8000_0000;
		end
		else
		begin
			clamped = value[31:0];
		end
		return clamped;
	endfunction

	////////////////////////////////////////
	// Stage 1, product
	////////////////////////////////////////

	// 16x16 signed fits 32 bits, even for -32768 squared
	assign prod_full = rd_data_a * rd_data_b;

	always_ff @(posedge clock)
	begin
		prod_q <= prod_full >>> PROD_SHIFT;
	end

	////////////////////////////////////////
	// Stage 2, accumulate
	////////////////////////////////////////

	// Clear and accumulate together start a new lag on its first product
	assign acc_base = bus.mac_clear ? '0 : acc;
	assign acc_add  = bus.mac_en ? lpc_pkg::acc_t'(prod_q) : '0;

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			acc <= '0;
		end
		else
		begin
			acc <= acc_base + acc_add;
		end
	end

	// Result held until the next store
	always_ff @(posedge clock)
	begin
		if (bus.store_en)
		begin
			result <= saturate(acc);
		end
	end

endmodule

//--- design/result_serializer.sv
`timescale 1ns/1ns

module result_serializer #(
	parameter int LAG_COUNT = 10,
	localparam int IDX_W = $clog2(LAG_COUNT)
) (
	input  logic           clock,
	input  logic           rst_n,
	input  lpc_pkg::corr_t result,
	mac_ctrl_if.ser_side   bus,
	output lpc_pkg::corr_t out,
	output logic           out_valid,
	output logic           done
);

	// One slot per lag, slot 0 holds r[1]
	lpc_pkg::corr_t slots [LAG_COUNT];

	logic             wr_pend;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	////////////////////////////////////////
	// Slot write
	////////////////////////////////////////

	// lag_mac registers result on store_en, so write one cycle later
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_pend <= 1'b0;
		end
		else
		begin
			wr_pend <= bus.store_en;
		end
	end

	always_ff @(posedge clock)
	begin
		if (bus.store_en)
		begin
			wr_idx <= bus.store_idx;
		end
		if (wr_pend)
		begin
			slots[wr_idx] <= result;
		end
	end

	////////////////////////////////////////
	// Output stream
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			done      <= 1'b0;
			rd_idx    <= '0;
		end
		else if (bus.emit_start)
		begin
			out_valid <= 1'b1;
			done      <= (LAG_COUNT == 1);
			rd_idx    <= IDX_W'(1);
		end
		else if (done)
		begin
			// Tenth word just went out
			out_valid <= 1'b0;
			done      <= 1'b0;
		end
		else if (out_valid)
		begin
			rd_idx <= rd_idx + 1'b1;
			done   <= (rd_idx == IDX_W'(LAG_COUNT - 1));
		end
	end

	// Word register, loaded on emit and on each step
	always_ff @(posedge clock)
	begin
		if (bus.emit_start)
		begin
			out <= slots[0];
		end
		else if (out_valid && !done)
		begin
			out <= slots[rd_idx];
		end
	end

endmodule

//--- design/lpc_control.sv
`timescale 1ns/1ns

module lpc_control #(
	parameter int FRAME_LEN = 80,
	parameter int LAG_COUNT = 10,
	localparam int ADDR_W = $clog2(FRAME_LEN)
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              start,
	output logic [ADDR_W-1:0] wr_addr,
	mac_ctrl_if.ctrl          bus
);

	localparam int IDX_W = $clog2(LAG_COUNT);
	localparam int LAG_W = $clog2(LAG_COUNT + 1);

	// Token bits travelling with each issued address
	localparam int TOK_EN    = 0;
	localparam int TOK_CLR   = 1;
	localparam int TOK_STORE = 2;
	localparam int TOK_EMIT  = 3;

	lpc_pkg::ctrl_state_t state;

	logic [LAG_W-1:0]  lag;
	logic [ADDR_W-1:0] n_idx;
	logic              frame_full;
	logic              last_n;
	logic              last_lag;
	logic [3:0]        tok_now;
	logic [3:0]        tok_d1;
	logic [3:0]        tok_d2;
	logic [IDX_W-1:0]  idx_now;
	logic [IDX_W-1:0]  idx_d1;
	logic [IDX_W-1:0]  idx_d2;

	////////////////////////////////////////
	// Sample counter and bank swap
	////////////////////////////////////////

	assign frame_full = start && (wr_addr == ADDR_W'(FRAME_LEN - 1));

	// Runs on its own so the next frame loads during the MAC loops
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_addr     <= '0;
			bus.rd_bank <= 1'b0;
		end
		else if (frame_full)
		begin
			wr_addr     <= '0;
			bus.rd_bank <= ~bus.rd_bank;
		end
		else if (start)
		begin
			wr_addr <= wr_addr + 1'b1;
		end
	end

	////////////////////////////////////////
	// Lag loop FSM
	////////////////////////////////////////

	assign last_n   = (n_idx == ADDR_W'(FRAME_LEN - 1));
	assign last_lag = (lag == LAG_W'(LAG_COUNT));

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= lpc_pkg::IDLE;
			lag   <= '0;
			n_idx <= '0;
		end
		else
		begin
			case (state)
				lpc_pkg::IDLE:
				begin
					if (start)
					begin
						state <= lpc_pkg::LOAD_WAIT;
					end
				end
				lpc_pkg::LOAD_WAIT:
				begin
					// Bank swaps on this same edge
					if (frame_full)
					begin
						state <= lpc_pkg::MAC_RUN;
						lag   <= LAG_W'(1);
						n_idx <= ADDR_W'(1);
					end
				end
				lpc_pkg::MAC_RUN:
				begin
					if (last_n)
					begin
						state <= lpc_pkg::MAC_STORE;
					end
					else
					begin
						n_idx <= n_idx + 1'b1;
					end
				end
				lpc_pkg::MAC_STORE:
				begin
					if (last_lag)
					begin
						state <= lpc_pkg::EMIT;
					end
					else
					begin
						// Inner loop restarts at n = k
						state <= lpc_pkg::MAC_RUN;
						lag   <= lag + 1'b1;
						n_idx <= ADDR_W'(lag) + 1'b1;
					end
				end
				lpc_pkg::EMIT:
				begin
					state <= lpc_pkg::LOAD_WAIT;
				end
				default:
				begin
					state <= lpc_pkg::IDLE;
				end
			endcase
		end
	end

	// Read addresses x[n] and x[n-k]
	assign bus.rd_addr_a = n_idx;
	assign bus.rd_addr_b = n_idx - ADDR_W'(lag);

	////////////////////////////////////////
	// Two-cycle alignment to the MAC
	////////////////////////////////////////

	assign idx_now = IDX_W'(lag - 1'b1);

	always_comb
	begin
		tok_now            = '0;
		tok_now[TOK_EN]    = (state == lpc_pkg::MAC_RUN);
		tok_now[TOK_CLR]   = (state == lpc_pkg::MAC_RUN) && (n_idx == ADDR_W'(lag));
		tok_now[TOK_STORE] = (state == lpc_pkg::MAC_STORE);
		tok_now[TOK_EMIT]  = (state == lpc_pkg::EMIT);
	end

	// Read cycle plus product cycle
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tok_d1 <= '0;
			tok_d2 <= '0;
		end
		else
		begin
			tok_d1 <= tok_now;
			tok_d2 <= tok_d1;
		end
	end

	always_ff @(posedge clock)
	begin
		idx_d1 <= idx_now;
		idx_d2 <= idx_d1;
	end

	assign bus.mac_en     = tok_d2[TOK_EN];
	assign bus.mac_clear  = tok_d2[TOK_CLR];
	assign bus.store_en   = tok_d2[TOK_STORE];
	assign bus.emit_start = tok_d2[TOK_EMIT];
	assign bus.store_idx  = idx_d2;

endmodule

//--- design/lpc_frontend_top.sv
`timescale 1ns/1ns

module lpc_frontend_top #(
	parameter int FRAME_LEN  = 80,
	parameter int LAG_COUNT  = 10,
	parameter int PROD_SHIFT = 6
) (
	input  logic        clock,
	input  logic        rst_n,
	input  logic        start,
	input  logic [15:0] in,
	output logic [31:0] out,
	output logic        out_valid,
	output logic        done
);

	localparam int ADDR_W = $clog2(FRAME_LEN);

	logic [ADDR_W-1:0] wr_addr;
	lpc_pkg::sample_t  rd_data_a;
	lpc_pkg::sample_t  rd_data_b;
	lpc_pkg::corr_t    result;

	// Controller to datapath bundle
	mac_ctrl_if #(
		.FRAME_LEN(FRAME_LEN),
		.LAG_COUNT(LAG_COUNT)
	) ctrl_bus ();

	lpc_control #(
		.FRAME_LEN(FRAME_LEN),
		.LAG_COUNT(LAG_COUNT)
	) lpc_control_i (
		.clock   (clock),
		.rst_n   (rst_n),
		.start   (start),
		.wr_addr (wr_addr),
		.bus     (ctrl_bus.ctrl)
	);

	frame_buffer #(
		.FRAME_LEN(FRAME_LEN)
	) frame_buffer_i (
		.clock     (clock),
		.start     (start),
		.in        (in),
		.wr_addr   (wr_addr),
		.bus       (ctrl_bus.buf_side),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	lag_mac #(
		.PROD_SHIFT(PROD_SHIFT)
	) lag_mac_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.bus       (ctrl_bus.mac_side),
		.result    (result)
	);

	result_serializer #(
		.LAG_COUNT(LAG_COUNT)
	) result_serializer_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.result    (result),
		.bus       (ctrl_bus.ser_side),
		.out       (out),
		.out_valid (out_valid),
		.done      (done)
	);

endmodule

//--- tb/lpc_frontend_sva.sv
`timescale 1ns/1ns

module lpc_frontend_sva #(
	parameter int MIN_GAP   = 12,
	parameter int BURST_LEN = 10
) (
	input logic clock,
	input logic rst_n,
	input logic start,
	input logic out_valid,
	input logic done
);

	// Spacing that lets the lag loops finish in time
	property start_spacing;
		@(posedge clock) disable iff (!rst_n)
			start |=> !start [*MIN_GAP-1];
	endproperty

	// Last word flag only on a valid word
	property done_with_valid;
		@(posedge clock) disable iff (!rst_n)
			done |-> out_valid;
	endproperty

	// One unbroken burst per frame
	property burst_length;
		@(posedge clock) disable iff (!rst_n)
			$rose(out_valid) |-> out_valid [*BURST_LEN] ##1 !out_valid;
	endproperty

	start_spacing_a: assert property (start_spacing)
		else $error("start strobes closer than %0d cycles", MIN_GAP);

	done_with_valid_a: assert property (done_with_valid)
		else $error("done high without out_valid");

	burst_length_a: assert property (burst_length)
		else $error("out_valid burst not exactly %0d cycles", BURST_LEN);

endmodule

bind lpc_frontend_top lpc_frontend_sva #(
	.BURST_LEN(LAG_COUNT)
) lpc_frontend_sva_i (
	.clock     (clock),
	.rst_n     (rst_n),
	.start     (start),
	.out_valid (out_valid),
	.done      (done)
);

//--- tb/tb_lpc_frontend.sv
`timescale 1ns/1ns

module tb_lpc_frontend;

	localparam int FRAME_LEN   = 80;
	localparam int LAG_COUNT   = 10;
	localparam int FRAMES      = 2;
	localparam int FRAME_WORDS = FRAME_LEN + LAG_COUNT;
	localparam int TIMEOUT     = 2000;
	localparam int LOAD_LIMIT  = FRAME_LEN * 24;
	localparam int SEED        = 11325;

	logic        clock;
	logic        rst_n;
	logic        start;
	logic [15:0] in;
	logic [31:0] out;
	logic        out_valid;
	logic        done;

	// Per frame: 80 samples, then r[1]..r[10]
	logic [31:0] vectors [FRAMES * FRAME_WORDS];

	// Words seen by the monitor
	logic [31:0] got_words [$];

	int frames_loaded;
	int run_len;

	lpc_frontend_top lpc_frontend_top_i (
		.clock     (clock),
		.rst_n     (rst_n),
		.start     (start),
		.in        (in),
		.out       (out),
		.out_valid (out_valid),
		.done      (done)
	);

	////////////////////////////////////////
	// Clock
	////////////////////////////////////////

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////
	// Check and stop helpers
	////////////////////////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		$display("Simulation failed");
		$fatal(1, "timeout");
	endtask

	////////////////////////////////////////
	// Output monitor
	////////////////////////////////////////

	// Samples mid-cycle, where the DUT outputs are stable
	always @(negedge clock)
	begin
		if (rst_n)
		begin
			// Nothing may come out before a full frame
			if (frames_loaded == 0)
			begin
				check_value(32'(out_valid), 32'd0, "out_valid before the first full frame");
				check_value(32'(done), 32'd0, "done before the first full frame");
			end
			if (out_valid)
			begin
				got_words.push_back(out);
				run_len++;
				// done only on the tenth word
				check_value(32'(done), 32'(run_len == LAG_COUNT), "done position in burst");
			end
			else if (run_len != 0)
			begin
				check_value(32'(run_len), 32'(LAG_COUNT), "out_valid burst length");
				run_len = 0;
			end
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Strobes 12 to 20 cycles apart, driven 2 ns after the edge
	task automatic send_frame(input int frame);
		int gap;
		for (int n = 0; n < FRAME_LEN; n++)
		begin
			@(posedge clock);
			#2;
			start = 1'b1;
			in    = vectors[frame * FRAME_WORDS + n][15:0];
			@(posedge clock);
			#2;
			start = 1'b0;
			gap   = 12 + int'($urandom % 9);
			repeat (gap - 2) @(posedge clock);
		end
		frames_loaded++;
	endtask

	////////////////////////////////////////
	// Result checks
	////////////////////////////////////////

	task automatic check_frame(input int frame);
		int base;
		int cycles;
		base   = frame * FRAME_WORDS + FRAME_LEN;
		cycles = 0;
		// Frame must be fully loaded first
		while (frames_loaded <= frame)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > LOAD_LIMIT)
			begin
				stop_on_timeout("the frame was never fully loaded");
			end
		end
		cycles = 0;
		while (done !== 1'b1)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > TIMEOUT)
			begin
				stop_on_timeout("no result arrived after the frame was loaded");
			end
		end
		// One more falling edge so the monitor holds the tenth word
		@(negedge clock);
		check_value(32'(got_words.size()), 32'((frame + 1) * LAG_COUNT), "word count");
		for (int k = 0; k < LAG_COUNT; k++)
		begin
			check_value(got_words[frame * LAG_COUNT + k], vectors[base + k],
				$sformatf("frame %0d lag r[%0d]", frame + 1, k + 1));
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		rst_n         = 1'b0;
		start         = 1'b0;
		in            = '0;
		frames_loaded = 0;
		run_len       = 0;
		void'($urandom(SEED));
		$readmemh("tb/lpc_vectors.hex", vectors);
		repeat (16) @(posedge clock);
		#2;
		rst_n = 1'b1;
		// Frame 2 loads while frame 1 is still computing
		fork
			begin
				for (int f = 0; f < FRAMES; f++)
				begin
					send_frame(f);
				end
			end
			begin
				for (int f = 0; f < FRAMES; f++)
				begin
					check_frame(f);
				end
			end
		join
		// Let the last burst length check run
		repeat (2) @(negedge clock);
		check_value(32'(got_words.size()), 32'(FRAMES * LAG_COUNT), "total word count");
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- tb/lpc_vectors.hex
// Per frame: 20 lines of four 16-bit samples x[n] in order, then ten 32-bit lags
// r[1]..r[10], each the 40-bit sum of (x[n]*x[n-k]) >>> 6 saturated to 32 bits
// Frame 1: x[n] = 1000 for even n, -300 for odd n
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
03e8 fed4 03e8 fed4
// Frame 1 lags r[1]..r[10]
fffa5950
000a2291
fffa7df0
0009e00a
fffaa290
00099d83
fffac730
00095afc
fffaebd0
00091875
// Frame 2: full scale, x[n] = 32767 for even n, -32768 for odd n
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
7fff 8000 7fff 8000
// Frame 2 lags r[1]..r[10]
b1009e00
4dff6400
b3009a00
4bff6800
b5009600
49ff6c00
b7009200
47ff7000
b9008e00
45ff7400

//--- flist.f
design/lpc_pkg.sv
design/mac_ctrl_if.sv
design/frame_buffer.sv
design/lag_mac.sv
design/result_serializer.sv
design/lpc_control.sv
design/lpc_frontend_top.sv
tb/lpc_frontend_sva.sv
tb/tb_lpc_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LPC front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_lpc_frontend \
	-f flist.f

# The log decides pass or fail, not the exit status
./obj_dir/Vtb_lpc_frontend > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation passed" sim.log
echo "run_sim.sh: pass message found in sim.log"
